// ==== rtl/scaler_config.svh ====
`ifndef SCALER_CONFIG_SVH
`define SCALER_CONFIG_SVH

// Bits per sample in the line buffer and on the output
`define SCALER_PIX_WIDTH 8

// Entries in the line buffer, so the longest source line
`define SCALER_LINE_DEPTH 64

// Width of a line length or a sample index
// Must be wide enough to hold SCALER_LINE_DEPTH itself
`define SCALER_RESO_WIDTH 7

`endif

// ==== rtl/scaler_ctrl_pkg.sv ====
`include "scaler_config.svh"

package scaler_ctrl_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Host commands
	// ~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [1:0] {
		OP_NOP   = 2'd0,
		OP_SIZE  = 2'd1,
		OP_WRITE = 2'd2,
		OP_START = 2'd3
	} scaler_opcode_e;

	// OP_SIZE puts the source length in a and the output length in the low bits of b
	// OP_WRITE carries the sample in the low bits of b
	typedef struct packed {
		scaler_opcode_e                op;
		logic [`SCALER_RESO_WIDTH-1:0] a;
		logic [14:0]                   b;
	} scaler_cmd_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Engine control
	// ~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_RESTART = 2'd1,
		ST_RUN     = 2'd2,
		ST_DONE    = 2'd3
	} engine_state_e;

endpackage

// ==== rtl/scaler_pixel_pkg.sv ====
`include "scaler_config.svh"

package scaler_pixel_pkg;

	typedef logic [`SCALER_PIX_WIDTH-1:0] pix_t;

	// One output to be blended
	// Phase counts quarters from near toward far, 0 to 4
	typedef struct packed {
		pix_t       near;
		pix_t       far;
		logic [2:0] phase;
		logic       last;
	} blend_req_t;

	// A finished output sample with its position in the output line
	typedef struct packed {
		pix_t                          value;
		logic [`SCALER_RESO_WIDTH-1:0] index;
		logic                          last;
	} out_sample_t;

endpackage

// ==== rtl/scaler_cmd_decode.sv ====
`timescale 1ns/1ps
`include "scaler_config.svh"

module scaler_cmd_decode
	import scaler_ctrl_pkg::*;
	import scaler_pixel_pkg::*;
(
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          i_cmd_valid,
	input  scaler_cmd_t                   i_cmd,
	input  logic                          i_busy,
	input  logic [`SCALER_RESO_WIDTH-1:0] i_rd_addr,
	output logic [`SCALER_RESO_WIDTH-1:0] o_src_size,
	output logic [`SCALER_RESO_WIDTH-1:0] o_dst_size,
	output pix_t                          o_rd_data,
	output logic                          o_start,
	output logic                          o_cmd_error
);
	localparam int ADDR_WIDTH = $clog2(`SCALER_LINE_DEPTH);
	localparam logic [`SCALER_RESO_WIDTH-1:0] MAX_SRC = `SCALER_RESO_WIDTH'(`SCALER_LINE_DEPTH);

	pix_t line_mem [`SCALER_LINE_DEPTH];
	logic [ADDR_WIDTH-1:0] wr_ptr;
	logic is_size;
	logic is_write;
	logic is_start;
	logic size_ok;
	logic bad_start;
	logic bad_size;

	always_comb begin
		is_size = 1'b0;
		is_write = 1'b0;
		is_start = 1'b0;
		if (i_cmd_valid) begin
			unique case (i_cmd.op)
				OP_SIZE:  is_size = 1'b1;
				OP_WRITE: is_write = 1'b1;
				OP_START: is_start = 1'b1;
				default:  ;
			endcase
		end
	end

	// A run needs both lengths set, and the source line must fit the buffer
	assign size_ok = (o_src_size != '0) && (o_dst_size != '0) && (o_src_size <= MAX_SRC);
	assign bad_start = is_start && (i_busy || !size_ok);
	assign bad_size = is_size && i_busy;

	// The start pulse goes out in the same cycle as the command
	assign o_start = is_start && !i_busy && size_ok;

	always_ff @(posedge clk) begin
		if (resetn == 1'b0) begin
			o_src_size <= '0;
			o_dst_size <= '0;
			wr_ptr <= '0;
		end else if (is_size && !i_busy) begin
			o_src_size <= i_cmd.a;
			o_dst_size <= i_cmd.b[`SCALER_RESO_WIDTH-1:0];
			wr_ptr <= '0;
		end else if (is_write) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (resetn == 1'b0)
			o_cmd_error <= 1'b0;
		else if (bad_start || bad_size)
			o_cmd_error <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (is_write)
			line_mem[wr_ptr] <= i_cmd.b[`SCALER_PIX_WIDTH-1:0];
	end

	// Asynchronous read for the engine
	assign o_rd_data = line_mem[i_rd_addr[ADDR_WIDTH-1:0]];

endmodule

// ==== rtl/bilinear_scaler.sv ====
`timescale 1ns/1ps

module bilinear_scaler #(
	parameter integer C_RESO_WIDTH = 10
) (
	input  logic                    clk,
	input  logic                    resetn,

	input  logic [C_RESO_WIDTH-1:0] ori_size,
	input  logic [C_RESO_WIDTH-1:0] scale_size,

	input  logic                    update_mul,

	output logic                    m_repeat_line,
	output logic [C_RESO_WIDTH-1:0] m_inv_cnt,
	output logic [C_RESO_WIDTH-1:0] o_inv_cnt,

	output logic                    m_ovalid,

	output logic [2:0]              ratio
);
	// Positions are kept at four times (2i+1) times the other length,
	// so source and output centres compare exactly and the quarter
	// boundaries fall on whole numbers
	localparam integer C_CMP_WIDTH = C_RESO_WIDTH * 2 + 3;

	logic [C_CMP_WIDTH-1:0] ori_ext;
	logic [C_CMP_WIDTH-1:0] scale_ext;

	// Next source centre, which is the right end of the current interval
	logic [C_CMP_WIDTH-1:0] m_mul;
	// Current output centre and the one after it
	logic [C_CMP_WIDTH-1:0] o_mul;
	logic [C_CMP_WIDTH-1:0] o_mul_next;
	// Quarter boundaries of the current interval, 1/8, 3/8, 5/8 and 7/8 of the way
	logic [C_CMP_WIDTH-1:0] m_spliter [4];

	logic update_mmul;
	logic update_omul;

	assign ori_ext = C_CMP_WIDTH'(ori_size);
	assign scale_ext = C_CMP_WIDTH'(scale_size);

	assign m_ovalid = m_mul > o_mul;
	// Hold the source while the following output still lies before the next centre
	assign m_repeat_line = m_mul > o_mul_next;

	assign ratio = (o_mul >= m_spliter[3]) ? 3'd4 :
		(o_mul >= m_spliter[2]) ? 3'd3 :
		(o_mul >= m_spliter[1]) ? 3'd2 :
		(o_mul >= m_spliter[0]) ? 3'd1 : 3'd0;

	assign update_mmul = update_mul && !m_repeat_line;
	assign update_omul = update_mul && m_ovalid;

	// ~~~~~~~~~~~~~~~~~~~~
	// Source side
	// ~~~~~~~~~~~~~~~~~~~~

	// The last source sample reaches to the line end, so every remaining output falls due
	always_ff @(posedge clk) begin
		if (resetn == 1'b0)
			m_mul <= (ori_size == 1) ? scale_ext * 8 : scale_ext * 12;
		else if (update_mmul) begin
			case (m_inv_cnt)
				1:       m_mul <= m_mul;
				2:       m_mul <= m_mul + scale_ext * 4;
				default: m_mul <= m_mul + scale_ext * 8;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (resetn == 1'b0) begin
			m_spliter[0] <= scale_ext * 5;
			m_spliter[1] <= scale_ext * 7;
			m_spliter[2] <= scale_ext * 9;
			m_spliter[3] <= scale_ext * 11;
		end else if (update_mmul && m_inv_cnt != 1) begin
			// The old right end becomes the new interval start
			m_spliter[0] <= m_mul + scale_ext;
			m_spliter[1] <= m_mul + scale_ext * 3;
			m_spliter[2] <= m_mul + scale_ext * 5;
			m_spliter[3] <= m_mul + scale_ext * 7;
		end
	end

	// Stops at 1 while the last sample is repeated
	always_ff @(posedge clk) begin
		if (resetn == 1'b0)
			m_inv_cnt <= ori_size;
		else if (update_mmul && m_inv_cnt != 1)
			m_inv_cnt <= m_inv_cnt - 1'b1;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Output side
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (resetn == 1'b0) begin
			o_mul <= ori_ext * 4;
			o_mul_next <= ori_ext * 12;
		end else if (update_omul) begin
			o_mul <= o_mul_next;
			o_mul_next <= o_mul_next + ori_ext * 8;
		end
	end

	always_ff @(posedge clk) begin
		if (resetn == 1'b0)
			o_inv_cnt <= scale_size;
		else if (update_omul)
			o_inv_cnt <= o_inv_cnt - 1'b1;
	end

endmodule

// ==== rtl/scaler_engine.sv ====
`timescale 1ns/1ps
`include "scaler_config.svh"

module scaler_engine
	import scaler_ctrl_pkg::*;
	import scaler_pixel_pkg::*;
(
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          i_start,
	input  logic [`SCALER_RESO_WIDTH-1:0] i_src_size,
	input  logic [`SCALER_RESO_WIDTH-1:0] i_dst_size,
	input  pix_t                          i_rd_data,
	output logic [`SCALER_RESO_WIDTH-1:0] o_rd_addr,
	output logic                          o_busy,
	output logic                          o_req_valid,
	output blend_req_t                    o_req
);
	localparam int RW = `SCALER_RESO_WIDTH;

	engine_state_e state;
	engine_state_e state_next;

	logic [RW-1:0] src_idx;
	pix_t near_q;
	logic busy_q;

	logic step_resetn;
	logic step_update;
	logic m_repeat_line;
	logic m_ovalid;
	logic [RW-1:0] m_inv_cnt;
	logic [RW-1:0] o_inv_cnt;
	logic [2:0] ratio;

	logic at_end;
	logic advance;
	logic last_out;

	// The stepper reloads from the sizes while the engine sits in ST_RESTART
	assign step_resetn = resetn && (state != ST_RESTART);
	assign step_update = (state == ST_RUN);

	// m_inv_cnt reads 1 once the source index sits on the last sample
	assign at_end = (m_inv_cnt == RW'(1));
	assign advance = step_update && !m_repeat_line && !at_end;
	assign last_out = m_ovalid && (o_inv_cnt == RW'(1));

	bilinear_scaler #(
		.C_RESO_WIDTH(RW)
	) bilinear_scaler_inst (
		.clk(clk),
		.resetn(step_resetn),
		.ori_size(i_src_size),
		.scale_size(i_dst_size),
		.update_mul(step_update),
		.m_repeat_line(m_repeat_line),
		.m_inv_cnt(m_inv_cnt),
		.o_inv_cnt(o_inv_cnt),
		.m_ovalid(m_ovalid),
		.ratio(ratio)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// Run FSM
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		state_next = state;
		unique case (state)
			ST_IDLE:    if (i_start) state_next = ST_RESTART;
			ST_RESTART: state_next = ST_RUN;
			ST_RUN:     if (last_out) state_next = ST_DONE;
			ST_DONE:    state_next = ST_IDLE;
			default:    state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (resetn == 1'b0)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	// Busy stays up through ST_DONE and drops the cycle after the last output
	always_ff @(posedge clk) begin
		if (resetn == 1'b0)
			busy_q <= 1'b0;
		else if (state == ST_IDLE && i_start)
			busy_q <= 1'b1;
		else if (state == ST_DONE)
			busy_q <= 1'b0;
	end

	assign o_busy = busy_q;

	// ~~~~~~~~~~~~~~~~~~~~
	// Sample fetch
	// ~~~~~~~~~~~~~~~~~~~~

	// The single read port always looks one sample ahead. The near sample is
	// kept here, and the far one becomes near when the source advances
	always_comb begin
		if (state == ST_RESTART)
			o_rd_addr = '0;
		else if (at_end)
			o_rd_addr = src_idx;
		else
			o_rd_addr = src_idx + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (resetn == 1'b0)
			src_idx <= '0;
		else if (state == ST_RESTART)
			src_idx <= '0;
		else if (advance)
			src_idx <= src_idx + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (state == ST_RESTART || advance)
			near_q <= i_rd_data;
	end

	assign o_req_valid = step_update && m_ovalid;

	always_comb begin
		o_req.near = near_q;
		o_req.far = i_rd_data;
		o_req.phase = ratio;
		o_req.last = (o_inv_cnt == RW'(1));
	end

endmodule

// ==== rtl/scaler_result.sv ====
`timescale 1ns/1ps
`include "scaler_config.svh"

module scaler_result
	import scaler_pixel_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  logic        i_req_valid,
	input  blend_req_t  i_req,
	output logic        o_out_valid,
	output out_sample_t o_out
);
	// Room for four full samples plus the rounding term
	localparam int SW = `SCALER_PIX_WIDTH + 3;

	logic [2:0] near_w;
	logic [2:0] far_w;
	logic [SW-1:0] blend_sum;
	logic [`SCALER_RESO_WIDTH-1:0] out_idx;

	assign far_w = i_req.phase;
	assign near_w = 3'd4 - i_req.phase;

	// Weights add up to four, so dividing by four after adding two rounds to nearest
	assign blend_sum = SW'(i_req.near) * SW'(near_w)
		+ SW'(i_req.far) * SW'(far_w)
		+ SW'(2);

	always_ff @(posedge clk) begin
		if (resetn == 1'b0)
			o_out_valid <= 1'b0;
		else
			o_out_valid <= i_req_valid;
	end

	always_ff @(posedge clk) begin
		if (i_req_valid) begin
			o_out.value <= blend_sum[SW-2:2];
			o_out.index <= out_idx;
			o_out.last <= i_req.last;
		end
	end

	// Numbering starts over after the last sample of a run
	always_ff @(posedge clk) begin
		if (resetn == 1'b0)
			out_idx <= '0;
		else if (i_req_valid)
			out_idx <= i_req.last ? '0 : out_idx + 1'b1;
	end

endmodule

// ==== rtl/line_scaler_top.sv ====
`timescale 1ns/1ps
`include "scaler_config.svh"

module line_scaler_top
	import scaler_ctrl_pkg::*;
	import scaler_pixel_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  logic        i_cmd_valid,
	input  scaler_cmd_t i_cmd,
	output logic        o_out_valid,
	output out_sample_t o_out,
	output logic        o_busy,
	output logic        o_cmd_error
);
	logic [`SCALER_RESO_WIDTH-1:0] src_size;
	logic [`SCALER_RESO_WIDTH-1:0] dst_size;
	logic [`SCALER_RESO_WIDTH-1:0] rd_addr;
	pix_t rd_data;
	logic start;
	logic req_valid;
	blend_req_t req;

	scaler_cmd_decode scaler_cmd_decode_inst (
		.clk(clk),
		.resetn(resetn),
		.i_cmd_valid(i_cmd_valid),
		.i_cmd(i_cmd),
		.i_busy(o_busy),
		.i_rd_addr(rd_addr),
		.o_src_size(src_size),
		.o_dst_size(dst_size),
		.o_rd_data(rd_data),
		.o_start(start),
		.o_cmd_error(o_cmd_error)
	);

	scaler_engine scaler_engine_inst (
		.clk(clk),
		.resetn(resetn),
		.i_start(start),
		.i_src_size(src_size),
		.i_dst_size(dst_size),
		.i_rd_data(rd_data),
		.o_rd_addr(rd_addr),
		.o_busy(o_busy),
		.o_req_valid(req_valid),
		.o_req(req)
	);

	scaler_result scaler_result_inst (
		.clk(clk),
		.resetn(resetn),
		.i_req_valid(req_valid),
		.i_req(req),
		.o_out_valid(o_out_valid),
		.o_out(o_out)
	);

endmodule

// ==== testbench/tb_line_scaler.sv ====
`timescale 1ns/1ps

module tb_line_scaler
	import scaler_ctrl_pkg::*;
	import scaler_pixel_pkg::*;
();
	logic clk = 1'b0;
	logic resetn;
	logic i_cmd_valid;
	scaler_cmd_t i_cmd;
	logic o_out_valid;
	out_sample_t o_out;
	logic o_busy;
	logic o_cmd_error;

	logic [7:0] pat_mem [0:255];
	int case_base [$];
	logic [7:0] got_val [$];
	logic [6:0] got_idx [$];
	logic got_last [$];
	int cycle_count = 0;
	int cycle_limit = 100000;
	int tests_run = 0;
	int tests_failed = 0;
	int seed_val;

	line_scaler_top line_scaler_top_inst (
		.clk(clk),
		.resetn(resetn),
		.i_cmd_valid(i_cmd_valid),
		.i_cmd(i_cmd),
		.o_out_valid(o_out_valid),
		.o_out(o_out),
		.o_busy(o_busy),
		.o_cmd_error(o_cmd_error)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the run did not finish", cycle_count);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// Every output strobe is collected here and checked once the run has ended
	always @(negedge clk) begin
		if (o_out_valid) begin
			got_val.push_back(o_out.value);
			got_idx.push_back(o_out.index);
			got_last.push_back(o_out.last);
		end
	end

	function automatic string case_name(input int id);
		case (id)
			1: return "identity";
			2: return "up_8_20";
			3: return "up_5_16";
			4: return "down_20_7";
			5: return "constant";
			6: return "single_src";
			default: return "unknown";
		endcase
	endfunction

	task automatic apply_reset();
		@(posedge clk);
		resetn <= 1'b0;
		repeat (3) @(posedge clk);
		resetn <= 1'b1;
	endtask

	task automatic send_cmd(input scaler_opcode_e op, input logic [6:0] a,
		input logic [14:0] b);
		@(posedge clk);
		i_cmd_valid <= 1'b1;
		i_cmd.op <= op;
		i_cmd.a <= a;
		i_cmd.b <= b;
		@(posedge clk);
		i_cmd_valid <= 1'b0;
		i_cmd <= '0;
	endtask

	task automatic load_case(input int base);
		int src;
		int gap;
		src = pat_mem[base + 1];
		send_cmd(OP_SIZE, 7'(src), 15'(pat_mem[base + 2]));
		for (int k = 0; k < src; k++) begin
			gap = $urandom % 3;
			repeat (gap) @(posedge clk);
			send_cmd(OP_WRITE, 7'd0, {7'd0, pat_mem[base + 3 + k]});
		end
	endtask

	task automatic clear_capture();
		got_val.delete();
		got_idx.delete();
		got_last.delete();
	endtask

	task automatic wait_run_end();
		while (!(o_out_valid && o_out.last)) @(negedge clk);
		@(negedge clk);
		while (o_busy) @(negedge clk);
	endtask

	// Compares the captured stream with the expected samples of one case
	task automatic check_outputs(input int base, input string name, input bit err_expected,
		input int prior_errors);
		int src;
		int dst;
		int errors;
		logic [7:0] exp_val;
		src = pat_mem[base + 1];
		dst = pat_mem[base + 2];
		errors = prior_errors;
		if (got_val.size() != dst) begin
			$display("Mismatch %s output count: expected %0d, actual %0d",
				name, dst, got_val.size());
			errors++;
		end
		for (int k = 0; k < dst && k < got_val.size(); k++) begin
			exp_val = pat_mem[base + 3 + src + k];
			if (got_val[k] !== exp_val) begin
				$display("Mismatch %s value %0d: expected %0d, actual %0d",
					name, k, exp_val, got_val[k]);
				errors++;
			end
			if (got_idx[k] !== 7'(k)) begin
				$display("Mismatch %s index %0d: expected %0d, actual %0d",
					name, k, k, got_idx[k]);
				errors++;
			end
			if (got_last[k] !== (k == dst - 1)) begin
				$display("Mismatch %s last %0d: expected %0d, actual %0d",
					name, k, (k == dst - 1), got_last[k]);
				errors++;
			end
		end
		if (o_cmd_error !== err_expected) begin
			$display("Mismatch %s command error: expected %0b, actual %0b",
				name, err_expected, o_cmd_error);
			errors++;
		end
		tests_run++;
		if (errors != 0)
			tests_failed++;
		$display("test %s: %0d errors, %s", name, errors, (errors == 0) ? "pass" : "fail");
	endtask

	task automatic run_case(input int base, input string name);
		load_case(base);
		clear_capture();
		send_cmd(OP_START, 7'd0, 15'd0);
		wait_run_end();
		check_outputs(base, name, 1'b0, 0);
	endtask

	initial begin
		int base;
		int total;
		int errors;
		resetn = 1'b0;
		i_cmd_valid = 1'b0;
		i_cmd = '0;
		seed_val = $urandom(31120);

		// ~~~~~~~~~~~~~~~~~~~~
		// Read the cases
		// ~~~~~~~~~~~~~~~~~~~~
		$readmemh("testbench/line_scaler_patterns.txt", pat_mem);
		base = 0;
		total = 0;
		while (pat_mem[base + 1] != 8'h00) begin
			case_base.push_back(base);
			total += pat_mem[base + 1] + pat_mem[base + 2];
			base += 3 + pat_mem[base + 1] + pat_mem[base + 2];
		end
		// Writes take up to four cycles each, and the reruns below add two more cases
		cycle_limit = 12 * total + 1500;

		apply_reset();

		// Every case in turn, each start right after the previous run ends
		foreach (case_base[c])
			run_case(case_base[c], case_name(pat_mem[case_base[c]]));

		// A start with zero lengths must be refused
		apply_reset();
		clear_capture();
		send_cmd(OP_SIZE, 7'd0, 15'd0);
		send_cmd(OP_START, 7'd0, 15'd0);
		repeat (10) @(negedge clk);
		errors = 0;
		if (got_val.size() != 0 || o_busy) begin
			$display("Test zero_size: a start with zero lengths produced activity");
			errors++;
		end
		if (o_cmd_error !== 1'b1) begin
			$display("Mismatch zero_size command error: expected 1, actual %0b",
				o_cmd_error);
			errors++;
		end
		tests_run++;
		if (errors != 0)
			tests_failed++;
		$display("test zero_size: %0d errors, %s", errors, (errors == 0) ? "pass" : "fail");

		// Start and size commands during a run must leave the run untouched
		apply_reset();
		base = case_base[1];
		load_case(base);
		clear_capture();
		send_cmd(OP_START, 7'd0, 15'd0);
		while (!o_out_valid) @(negedge clk);
		send_cmd(OP_START, 7'd0, 15'd0);
		@(negedge clk);
		errors = 0;
		if (o_cmd_error !== 1'b1) begin
			$display("Mismatch busy_cmds command error after start: expected 1, actual %0b",
				o_cmd_error);
			errors++;
		end
		send_cmd(OP_SIZE, 7'd3, 15'd3);
		wait_run_end();
		check_outputs(base, "busy_cmds", 1'b1, errors);

		// A following run reuses the engine and must number from zero again
		base = case_base[0];
		load_case(base);
		clear_capture();
		send_cmd(OP_START, 7'd0, 15'd0);
		wait_run_end();
		check_outputs(base, "back_to_back", 1'b1, 0);

		$display("%0d tests, %0d passed, %0d failed",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/scaler_ctrl_pkg.sv
rtl/scaler_pixel_pkg.sv
rtl/scaler_cmd_decode.sv
rtl/bilinear_scaler.sv
rtl/scaler_engine.sv
rtl/scaler_result.sv
rtl/line_scaler_top.sv
testbench/tb_line_scaler.sv

// ==== Makefile ====
# Verilator simulation of the line scaler
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_line_scaler
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/line_scaler_patterns.txt ====
// Each case: id, source length, output length, then the source samples,
// then the expected output samples. A case with source length 00 ends the list.
// Identity, 6 to 6
01 06 06
0A 14 1E 28 32 3C
0A 14 1E 28 32 3C
// Upscale, 8 to 20
02 08 14
00 28 50 78 A0 C8 F0 64
00 00 14 28 32 46 50 64 78 82
96 A0 B4 C8 D2 E6 F0 AA 64 64
// Upscale, 5 to 16
03 05 10
14 64 3C C8 08
14 14 28 3C 64 5A 50 46 5F 82
A5 C8 68 38 08 08
// Downscale, 20 to 7
04 14 07
00 0C 18 24 30 3C 48 54 60 6C
78 84 90 9C A8 B4 C0 CC D8 E4
0C 2D 51 72 93 B7 D8
// Constant line, 9 to 13
05 09 0D
5A 5A 5A 5A 5A 5A 5A 5A 5A
5A 5A 5A 5A 5A 5A 5A 5A 5A 5A
5A 5A 5A
// Single source sample, 1 to 3
06 01 03
7E
7E 7E 7E
// End of list
00 00 00
